// File: files.f
source/pwm_pkg.sv
source/pwm_config_regs.sv
source/pwm_run_control.sv
source/pwm_counter.sv
source/pwm_compare.sv
source/pwm_pin_deadtime.sv
source/pwm_chain.sv
sim/pwm_chain_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the PWM chain testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f files.f --top-module pwm_chain_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vpwm_chain_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -q "Test failures found" "$log_file"
grep_status=$?
if [ $grep_status -eq 0 ]; then
    exit 1
elif [ $grep_status -ne 1 ]; then
    echo "Could not search the simulation log"
    exit 1
fi
exit 0

// File: sim/pwm_chain_tb.sv
// PWM chain testbench for start delay, duty and dead time, shadow reload and triangle sync
`default_nettype none

module pwm_chain_tb;

    localparam int n_channels = 4;
    localparam int period_value = 39;
    localparam int timeout_clocks = 2000;

    logic                  clock;
    logic                  reset;
    logic                  cfg_valid;
    pwm_pkg::reg_address_t cfg_address;
    pwm_pkg::reg_data_t    cfg_data;
    logic                  cfg_ready;
    logic                  run_request;
    logic                  stop_request;
    logic                  sync;
    logic                  timebase = 1'b1;
    logic                  counter_status;
    logic [n_channels-1:0] out_a;
    logic [n_channels-1:0] out_b;

    logic                  idle_check;
    logic                  strobe_half;
    logic [n_channels-1:0] enable_mask;
    int errors;
    int monitor_errors;
    int checks;
    int deadtime_value;
    int delay_value;
    int on_value [n_channels];
    int off_value [n_channels];
    int high_a [n_channels];
    int high_b [n_channels];
    int stalls;
    int stalls_second;
    int new_on;
    int new_off;
    int sync_offset;

    pwm_chain #(
        .n_channels (n_channels)
    ) dut (
        .clock          (clock),
        .reset          (reset),
        .cfg_valid      (cfg_valid),
        .cfg_address    (cfg_address),
        .cfg_data       (cfg_data),
        .cfg_ready      (cfg_ready),
        .run_request    (run_request),
        .stop_request   (stop_request),
        .sync           (sync),
        .timebase       (timebase),
        .counter_status (counter_status),
        .out_a          (out_a),
        .out_b          (out_b)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = !clock;
    end

    // Strobe every second clock in the triangle tests and hold it high otherwise
    always @(negedge clock) begin
        timebase <= strobe_half ? !timebase : 1'b1;
    end

    // Both switches of a pair must never conduct at once
    always @(negedge clock) begin
        assert ((out_a & out_b) == '0) else begin
            monitor_errors++;
            $display("Mismatch at time %0t: out_a %b and out_b %b high together",
                     $time, out_a, out_b);
        end
        if (idle_check) begin
            assert (!counter_status && out_a == '0 && out_b == '0 && cfg_ready) else begin
                monitor_errors++;
                $display("Mismatch at time %0t: idle expected, status %b out_a %b out_b %b",
                         $time, counter_status, out_a, out_b);
            end
        end
    end

    task automatic check_value(input string what, input int actual, input int expected);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Mismatch at time %0t: %s expected %0d, got %0d",
                     $time, what, expected, actual);
        end
    endtask

    function automatic pwm_pkg::reg_address_t threshold_address(input int channel,
                                                                input int off_side);
        return pwm_pkg::reg_address_t'(pwm_pkg::address_threshold_base + 2 * channel + off_side);
    endfunction

    // Called on a falling edge and returns on the falling edge after the accepting clock
    task automatic write_register(input pwm_pkg::reg_address_t address,
                                  input pwm_pkg::reg_data_t data, output int waited);
        cfg_valid   = 1'b1;
        cfg_address = address;
        cfg_data    = data;
        waited      = 0;
        while (!cfg_ready && waited < timeout_clocks) begin
            @(negedge clock);
            waited++;
        end
        if (waited >= timeout_clocks) begin
            errors++;
            $display("Write to address %0d was never accepted", address);
        end
        @(negedge clock);
        cfg_valid = 1'b0;
    endtask

    task automatic write_with_gap(input pwm_pkg::reg_address_t address, input int value);
        int waited;
        write_register(address, pwm_pkg::reg_data_t'(value), waited);
        check_value("stall clocks of a write while stopped", waited, 0);
        repeat ($urandom % 3) @(negedge clock);
    endtask

    task automatic wait_for_reload();
        int guard;
        guard = 0;
        while (cfg_ready && guard < timeout_clocks) begin
            @(negedge clock);
            guard++;
        end
        if (guard >= timeout_clocks) begin
            errors++;
            $display("Timed out waiting for a period boundary");
        end
    endtask

    task automatic count_high(input int clocks);
        for (int ch = 0; ch < n_channels; ch++) begin
            high_a[ch] = 0;
            high_b[ch] = 0;
        end
        repeat (clocks) begin
            @(negedge clock);
            for (int ch = 0; ch < n_channels; ch++) begin
                if (out_a[ch]) high_a[ch]++;
                if (out_b[ch]) high_b[ch]++;
            end
        end
    endtask

    // Window wide enough that both pulses survive the dead time
    task automatic pick_window(input int dead, output int on, output int off);
        on  = 1 + $urandom % 10;
        off = on + dead + 1 + $urandom % 20;
    endtask

    task automatic check_duty_sawtooth();
        int width;
        count_high(3 * (period_value + 1));
        for (int ch = 0; ch < n_channels; ch++) begin
            width = off_value[ch] - on_value[ch];
            if (enable_mask[ch]) begin
                check_value($sformatf("channel %0d out_a clocks", ch), high_a[ch],
                            3 * (width - deadtime_value));
                check_value($sformatf("channel %0d out_b clocks", ch), high_b[ch],
                            3 * (period_value + 1 - width - deadtime_value));
            end else begin
                check_value($sformatf("channel %0d out_a clocks", ch), high_a[ch], 0);
                check_value($sformatf("channel %0d out_b clocks", ch), high_b[ch], 0);
            end
        end
    endtask

    task automatic start_run(input int delay);
        int clocks;
        idle_check  = 1'b0;
        run_request = 1'b1;
        @(posedge clock);
        clocks = 0;
        do begin
            @(posedge clock);
            clocks++;
            @(negedge clock);
        end while (!counter_status && clocks < timeout_clocks);
        check_value("clocks from run_request to counter_status", clocks, delay + 1);
    endtask

    task automatic stop_run();
        stop_request = 1'b1;
        @(negedge clock);
        check_value("counter_status after stop_request", int'(counter_status), 0);
        @(negedge clock);
        check_value("out_a after stop", int'(out_a), 0);
        check_value("out_b after stop", int'(out_b), 0);
        run_request  = 1'b0;
        stop_request = 1'b0;
        @(negedge clock);
    endtask

    // Sync is issued where the next clock has no strobe so the restart phase is fixed
    task automatic measure_sync_offset(output int offset);
        int   guard;
        logic seen_low;
        guard = 0;
        while (!timebase && guard < timeout_clocks) begin
            @(negedge clock);
            guard++;
        end
        sync = 1'b1;
        @(negedge clock);
        sync     = 1'b0;
        offset   = 0;
        seen_low = 1'b0;
        do begin
            @(posedge clock);
            offset++;
            @(negedge clock);
            if (!out_a[0]) seen_low = 1'b1;
        end while (!(seen_low && out_a[0]) && offset < timeout_clocks);
        if (offset >= timeout_clocks) begin
            errors++;
            $display("Timed out waiting for out_a to rise after sync");
        end
    endtask

    initial begin
        void'($urandom(32'hc87dba26));
        reset        = 1'b0;
        cfg_valid    = 1'b0;
        cfg_address  = '0;
        cfg_data     = '0;
        run_request  = 1'b0;
        stop_request = 1'b0;
        sync         = 1'b0;
        idle_check   = 1'b1;
        strobe_half  = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        // Sawtooth setup with channel 2 left disabled
        deadtime_value = $urandom % 5;
        delay_value    = $urandom % 21;
        enable_mask    = 4'b1011;
        write_with_gap(pwm_pkg::address_period, period_value);
        write_with_gap(pwm_pkg::address_mode, int'(pwm_pkg::mode_sawtooth));
        write_with_gap(pwm_pkg::address_start_delay, delay_value);
        write_with_gap(pwm_pkg::address_deadtime, deadtime_value);
        write_with_gap(pwm_pkg::address_enable, int'(enable_mask));
        for (int ch = 0; ch < n_channels; ch++) begin
            pick_window(deadtime_value, on_value[ch], off_value[ch]);
            write_with_gap(threshold_address(ch, 0), on_value[ch]);
            write_with_gap(threshold_address(ch, 1), off_value[ch]);
        end

        start_run(delay_value);
        repeat (2 * (period_value + 1)) @(negedge clock);
        check_duty_sawtooth();

        // New channel 0 window written right at a period boundary
        pick_window(deadtime_value, new_on, new_off);
        wait_for_reload();
        fork
            begin
                write_register(threshold_address(0, 0), pwm_pkg::reg_data_t'(new_on), stalls);
                repeat ($urandom % 3) @(negedge clock);
                write_register(threshold_address(0, 1), pwm_pkg::reg_data_t'(new_off),
                               stalls_second);
            end
            count_high(period_value + 1);
        join
        check_value("stall clocks of the write at reload", stalls, 1);
        check_value("stall clocks of the write away from reload", stalls_second, 0);
        check_value("channel 0 out_a clocks with old window", high_a[0],
                    off_value[0] - on_value[0] - deadtime_value);
        count_high(period_value + 1);
        check_value("channel 0 out_a clocks with new window", high_a[0],
                    new_off - new_on - deadtime_value);
        on_value[0]  = new_on;
        off_value[0] = new_off;
        check_duty_sawtooth();
        stop_run();

        // Triangle with a strobe every second clock makes each count value last two clocks
        strobe_half = 1'b1;
        write_with_gap(pwm_pkg::address_mode, int'(pwm_pkg::mode_triangle));
        write_with_gap(pwm_pkg::address_start_delay, 0);
        start_run(0);
        repeat (4 * period_value + 20) @(negedge clock);
        count_high(8 * period_value);
        for (int ch = 0; ch < n_channels; ch++) begin
            // Two crossings per triangle and two triangles in the window
            check_value($sformatf("channel %0d triangle out_a clocks", ch), high_a[ch],
                        enable_mask[ch] ?
                        4 * (2 * (off_value[ch] - on_value[ch]) - deadtime_value) : 0);
        end
        repeat (2) begin
            measure_sync_offset(sync_offset);
            check_value("clocks from sync to out_a rise", sync_offset,
                        2 * on_value[0] + 1 + deadtime_value);
            repeat (3 + $urandom % 50) @(negedge clock);
        end
        stop_run();

        $display("Checks run: %0d, check errors: %0d, monitor errors: %0d",
                 checks, errors, monitor_errors);
        if (errors == 0 && monitor_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/pwm_chain.sv
// PWM chain top level joining configuration, run control, counter, compare and pin stages
`default_nettype none

module pwm_chain #(
    parameter int n_channels = 4
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     cfg_valid,
    input  pwm_pkg::reg_address_t   cfg_address,
    input  pwm_pkg::reg_data_t      cfg_data,
    output logic                    cfg_ready,
    input  wire                     run_request,
    input  wire                     stop_request,
    input  wire                     sync,
    input  wire                     timebase,
    output logic                    counter_status,
    output logic [n_channels-1:0]   out_a,
    output logic [n_channels-1:0]   out_b
);

    pwm_pkg::count_t        period;
    pwm_pkg::counter_mode_t counter_mode;
    pwm_pkg::delay_t        start_delay;
    pwm_pkg::deadtime_t     deadtime;
    logic [n_channels-1:0]  channel_enable;
    pwm_pkg::count_t        threshold_on [n_channels];
    pwm_pkg::count_t        threshold_off [n_channels];
    logic                   counter_enable;
    logic                   running;
    pwm_pkg::count_t        count;
    logic                   reload;
    logic [n_channels-1:0]  phase_a;

    assign counter_status = running;

    pwm_config_regs #(
        .n_channels (n_channels)
    ) config_regs (
        .clock          (clock),
        .reset          (reset),
        .cfg_valid      (cfg_valid),
        .cfg_address    (cfg_address),
        .cfg_data       (cfg_data),
        .reload         (reload),
        .running        (running),
        .cfg_ready      (cfg_ready),
        .period         (period),
        .counter_mode   (counter_mode),
        .start_delay    (start_delay),
        .deadtime       (deadtime),
        .channel_enable (channel_enable),
        .threshold_on   (threshold_on),
        .threshold_off  (threshold_off)
    );

    pwm_run_control run_control (
        .clock          (clock),
        .reset          (reset),
        .run_request    (run_request),
        .stop_request   (stop_request),
        .start_delay    (start_delay),
        .counter_enable (counter_enable),
        .running        (running)
    );

    pwm_counter counter (
        .clock          (clock),
        .reset          (reset),
        .counter_enable (counter_enable),
        .timebase       (timebase),
        .sync           (sync),
        .period         (period),
        .counter_mode   (counter_mode),
        .count          (count),
        .reload         (reload)
    );

    pwm_compare #(
        .n_channels (n_channels)
    ) compare (
        .clock         (clock),
        .reset         (reset),
        .count         (count),
        .threshold_on  (threshold_on),
        .threshold_off (threshold_off),
        .phase_a       (phase_a)
    );

    // One output pair per channel
    for (genvar i = 0; i < n_channels; i++) begin : g_pin
        pwm_pin_deadtime pin_stage (
            .clock          (clock),
            .reset          (reset),
            .phase_a        (phase_a[i]),
            .channel_enable (channel_enable[i]),
            .running        (running),
            .deadtime       (deadtime),
            .out_a          (out_a[i]),
            .out_b          (out_b[i])
        );
    end

endmodule

`default_nettype wire

// File: source/pwm_pin_deadtime.sv
// PWM pin stage driving one complementary output pair with dead-time insertion
`default_nettype none

module pwm_pin_deadtime (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 phase_a,
    input  wire                 channel_enable,
    input  wire                 running,
    input  pwm_pkg::deadtime_t  deadtime,
    output logic                out_a,
    output logic                out_b
);

    logic               phase_last;
    pwm_pkg::deadtime_t dead_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase_last <= 1'b0;
            dead_count <= '0;
            out_a      <= 1'b0;
            out_b      <= 1'b0;
        end else if (!channel_enable || !running) begin
            // Track the phase while off so the pair starts without a spurious gap
            phase_last <= phase_a;
            dead_count <= '0;
            out_a      <= 1'b0;
            out_b      <= 1'b0;
        end else if (phase_a != phase_last) begin
            phase_last <= phase_a;
            if (deadtime == '0) begin
                dead_count <= '0;
                out_a      <= phase_a;
                out_b      <= !phase_a;
            end else begin
                // Both switches open before the new side is allowed on
                dead_count <= deadtime;
                out_a      <= 1'b0;
                out_b      <= 1'b0;
            end
        end else if (dead_count != '0) begin
            dead_count <= dead_count - 1'b1;
            if (dead_count == 1) begin
                out_a <= phase_last;
                out_b <= !phase_last;
            end else begin
                out_a <= 1'b0;
                out_b <= 1'b0;
            end
        end else begin
            out_a <= phase_last;
            out_b <= !phase_last;
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_compare.sv
// PWM compare unit deciding per channel whether the pair is in its a phase
`default_nettype none

module pwm_compare #(
    parameter int n_channels = 4
) (
    input  wire                    clock,
    input  wire                    reset,
    input  pwm_pkg::count_t        count,
    input  pwm_pkg::count_t        threshold_on [n_channels],
    input  pwm_pkg::count_t        threshold_off [n_channels],
    output logic [n_channels-1:0]  phase_a
);

    logic [n_channels-1:0] in_window;

    // Window is closed at the on threshold and open at the off threshold
    always_comb begin
        for (int i = 0; i < n_channels; i++) begin
            in_window[i] = (count >= threshold_on[i]) && (count < threshold_off[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase_a <= '0;
        end else begin
            phase_a <= in_window;
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_counter.sv
// PWM period counter with sawtooth and triangle modes, sync clear and reload pulse
`default_nettype none

module pwm_counter (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     counter_enable,
    input  wire                     timebase,
    input  wire                     sync,
    input  pwm_pkg::count_t         period,
    input  pwm_pkg::counter_mode_t  counter_mode,
    output pwm_pkg::count_t         count,
    output logic                    reload
);

    logic counting_down;
    logic step;

    assign step = counter_enable && timebase;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count         <= '0;
            counting_down <= 1'b0;
            reload        <= 1'b0;
        end else begin
            reload <= 1'b0;
            if (sync || period == '0) begin
                count         <= '0;
                counting_down <= 1'b0;
            end else if (step) begin
                if (counter_mode == pwm_pkg::mode_sawtooth) begin
                    counting_down <= 1'b0;
                    if (count >= period) begin
                        count  <= '0;
                        reload <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end else if (counting_down || count >= period) begin
                    // Triangle top turns around, bottom flags the period boundary
                    count <= count - 1'b1;
                    if (count <= 1) begin
                        count         <= '0;
                        counting_down <= 1'b0;
                        reload        <= 1'b1;
                    end else begin
                        counting_down <= 1'b1;
                    end
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_run_control.sv
// PWM run controller applying the start delay and stop request to the counter
`default_nettype none

module pwm_run_control (
    input  wire              clock,
    input  wire              reset,
    input  wire              run_request,
    input  wire              stop_request,
    input  pwm_pkg::delay_t  start_delay,
    output logic             counter_enable,
    output logic             running
);

    pwm_pkg::run_state_t state;
    pwm_pkg::delay_t     delay_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= pwm_pkg::state_idle;
            delay_count <= '0;
        end else begin
            case (state)
                pwm_pkg::state_idle: begin
                    if (run_request && !stop_request) begin
                        state       <= pwm_pkg::state_delay;
                        delay_count <= start_delay;
                    end
                end
                pwm_pkg::state_delay: begin
                    // Stop always wins, even in the middle of the delay
                    if (stop_request || !run_request) begin
                        state <= pwm_pkg::state_idle;
                    end else if (delay_count == '0) begin
                        state <= pwm_pkg::state_running;
                    end else begin
                        delay_count <= delay_count - 1'b1;
                    end
                end
                pwm_pkg::state_running: begin
                    if (stop_request || !run_request) begin
                        state <= pwm_pkg::state_idle;
                    end
                end
                default: begin
                    state <= pwm_pkg::state_idle;
                end
            endcase
        end
    end

    // The counter only moves in the running state
    assign running = (state == pwm_pkg::state_running);
    assign counter_enable = (state == pwm_pkg::state_running);

endmodule

`default_nettype wire

// File: source/pwm_config_regs.sv
// PWM configuration write port with setting registers and double-buffered thresholds
`default_nettype none

module pwm_config_regs #(
    parameter int n_channels = 4
) (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         cfg_valid,
    input  pwm_pkg::reg_address_t       cfg_address,
    input  pwm_pkg::reg_data_t          cfg_data,
    input  wire                         reload,
    input  wire                         running,
    output logic                        cfg_ready,
    output pwm_pkg::count_t             period,
    output pwm_pkg::counter_mode_t      counter_mode,
    output pwm_pkg::delay_t             start_delay,
    output pwm_pkg::deadtime_t          deadtime,
    output logic [n_channels-1:0]       channel_enable,
    output pwm_pkg::count_t             threshold_on [n_channels],
    output pwm_pkg::count_t             threshold_off [n_channels]
);

    logic write;

    // Shadow bank, written by the port and copied at the period boundary
    pwm_pkg::count_t shadow_on [n_channels];
    pwm_pkg::count_t shadow_off [n_channels];

    // The copy cycle is the only time a write is held off
    assign cfg_ready = !reload;
    assign write = cfg_valid && cfg_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            period         <= '0;
            counter_mode   <= pwm_pkg::mode_sawtooth;
            start_delay    <= '0;
            deadtime       <= '0;
            channel_enable <= '0;
        end else if (write) begin
            case (cfg_address)
                pwm_pkg::address_period:      period <= pwm_pkg::count_t'(cfg_data);
                pwm_pkg::address_mode:        counter_mode <= pwm_pkg::counter_mode_t'(cfg_data[0]);
                pwm_pkg::address_start_delay: start_delay <= pwm_pkg::delay_t'(cfg_data);
                pwm_pkg::address_deadtime:    deadtime <= pwm_pkg::deadtime_t'(cfg_data[7:0]);
                pwm_pkg::address_enable:      channel_enable <= cfg_data[n_channels-1:0];
                // Threshold addresses are decoded per channel below, the rest are dropped
                default: ;
            endcase
        end
    end

    for (genvar i = 0; i < n_channels; i++) begin : g_threshold
        localparam pwm_pkg::reg_address_t on_address =
            pwm_pkg::reg_address_t'(pwm_pkg::address_threshold_base + 2 * i);
        localparam pwm_pkg::reg_address_t off_address =
            pwm_pkg::reg_address_t'(pwm_pkg::address_threshold_base + 2 * i + 1);

        always_ff @(posedge clock) begin
            if (!reset) begin
                shadow_on[i]     <= '0;
                shadow_off[i]    <= '0;
                threshold_on[i]  <= '0;
                threshold_off[i] <= '0;
            end else begin
                if (write && cfg_address == on_address) begin
                    shadow_on[i] <= pwm_pkg::count_t'(cfg_data);
                end
                if (write && cfg_address == off_address) begin
                    shadow_off[i] <= pwm_pkg::count_t'(cfg_data);
                end
                // While stopped the active bank tracks the shadow bank continuously
                if (reload || !running) begin
                    threshold_on[i]  <= shadow_on[i];
                    threshold_off[i] <= shadow_off[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pwm_pkg.sv
// PWM chain shared vector types, state enums and configuration address map
`default_nettype none

package pwm_pkg;

    // Counter value, period and compare thresholds share one width
    typedef logic [15:0] count_t;
    typedef logic [15:0] delay_t;
    typedef logic [7:0]  deadtime_t;
    typedef logic [3:0]  reg_address_t;
    typedef logic [15:0] reg_data_t;

    typedef enum logic {
        mode_sawtooth,
        mode_triangle
    } counter_mode_t;

    typedef enum logic [1:0] {
        state_idle,
        state_delay,
        state_running
    } run_state_t;

    // Write-only register map of the configuration port
    localparam reg_address_t address_period         = 4'd0;
    localparam reg_address_t address_mode           = 4'd1;
    localparam reg_address_t address_start_delay    = 4'd2;
    localparam reg_address_t address_deadtime       = 4'd3;
    localparam reg_address_t address_enable         = 4'd4;
    // Channel i owns base+2i (on) and base+2i+1 (off)
    localparam reg_address_t address_threshold_base = 4'd8;

endpackage

`default_nettype wire
